/* exec_core.f */
+incdir+include
hdl/cpu_pkg.sv
hdl/count_bit.sv
hdl/mdu_fsm.sv
hdl/mdu_counter.sv
hdl/mdu_datapath.sv
hdl/multi_cycle_exec.sv
hdl/instr_exec.sv
hdl/exec_core.sv
tests/exec_core_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f exec_core.f \
	--top-module exec_core_tb -o exec_core_sim > sim.log 2>&1 &&
./obj_dir/exec_core_sim >> sim.log 2>&1 &&
! grep -q "Regression failed" sim.log &&
grep -q "Regression passed" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

/* tests/exec_core_tb.sv */
`include "cpu_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb
	import cpu_pkg::*;
();

localparam int CLK_PERIOD = 100;
localparam int MDU_STEPS = 32;
// directed test task calls in the main sequence
localparam int NUM_TESTS = 62;
localparam virt_t TEST_PC = 32'h0040_1000;
localparam reg_addr_t RD_INDEX = 5'd9;

logic             clk;
logic             rst;
logic             flush;
logic             delayslot;
pipeline_decode_t data;
pipeline_exec_t   result;
branch_resolved_t resolved_branch;
logic             stall_req;
uint64_t          hilo;

int          errors;
int          tests;
logic [31:0] lcg_state;

oper_t alu_ops[17] = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ADDU, OP_SUBU, OP_SLL, OP_SRL,
	OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO, OP_LUI};

exec_core #(
	.MDU_STEPS ( MDU_STEPS )
) i_exec_core (
	.clk             ( clk             ),
	.rst             ( rst             ),
	.flush           ( flush           ),
	.delayslot       ( delayslot       ),
	.data            ( data            ),
	.result          ( result          ),
	.resolved_branch ( resolved_branch ),
	.stall_req       ( stall_req       ),
	.hilo            ( hilo            )
);

initial clk = 1'b0;
always #(CLK_PERIOD / 2) clk = ~clk;

function automatic logic [31:0] next_rand();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
	errors++;
	$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
endtask

task automatic report_failure(string what);
	errors++;
	$display("Error at %0t: %s", $time, what);
endtask

function automatic pipeline_decode_t make_op(oper_t op, uint32_t r1, uint32_t r2,
	uint32_t word);
	pipeline_decode_t d;
	d = '0;
	d.valid = 1'b1;
	d.pc = TEST_PC;
	d.instr = word;
	d.decoded.op = op;
	d.decoded.rd = RD_INDEX;
	d.decoded.is_load = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
	d.decoded.is_store = op inside {OP_SB, OP_SH, OP_SW};
	d.decoded.is_controlflow = op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ,
		OP_BGEZ, OP_BLTZAL, OP_BGEZAL, OP_J, OP_JAL, OP_JR, OP_JALR};
	d.reg1 = r1;
	d.reg2 = r2;
	return d;
endfunction

// inputs change on the rising edge, outputs are read at the falling edge
task automatic apply(pipeline_decode_t d);
	@(posedge clk);
	data <= d;
	@(negedge clk);
endtask

function automatic uint32_t alu_model(oper_t op, uint32_t r1, uint32_t r2, uint32_t word);
	logic [4:0] sa;
	logic       lead;
	int         n;
	int         i;
	sa = word[10:6];
	case (op)
		OP_AND:  return r1 & r2;
		OP_OR:   return r1 | r2;
		OP_XOR:  return r1 ^ r2;
		OP_NOR:  return ~(r1 | r2);
		OP_ADDU: return r1 + r2;
		OP_SUBU: return r1 - r2;
		OP_SLL:  return r2 << sa;
		OP_SRL:  return r2 >> sa;
		OP_SRA:  return $signed(r2) >>> sa;
		OP_SLLV: return r2 << r1[4:0];
		OP_SRLV: return r2 >> r1[4:0];
		OP_SRAV: return $signed(r2) >>> r1[4:0];
		OP_SLT:  return ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0;
		OP_SLTU: return (r1 < r2) ? 32'd1 : 32'd0;
		OP_LUI:  return {word[15:0], 16'h0000};
		OP_CLZ, OP_CLO: begin
			lead = (op == OP_CLO);
			n = 0;
			for (i = 31; i >= 0; i--) begin
				if (r1[i] != lead)
					break;
				n++;
			end
			return 32'(n);
		end
		default: return 32'd0;
	endcase
endfunction

function automatic uint64_t mdu_model(oper_t op, uint32_t r1, uint32_t r2);
	int a;
	int b;
	a = r1;
	b = r2;
	case (op)
		OP_MULT:  return {{32{r1[31]}}, r1} * {{32{r2[31]}}, r2};
		OP_MULTU: return {32'h0, r1} * {32'h0, r2};
		// zero divisor: quotient all ones, remainder is the dividend
		OP_DIVU:  return (r2 == 0) ? {r1, 32'hffff_ffff} : {r1 % r2, r1 / r2};
		default:  return (r2 == 0) ? {r1, 32'hffff_ffff} : {32'(a % b), 32'(a / b)};
	endcase
endfunction

function automatic logic branch_taken_model(oper_t op, uint32_t r1, uint32_t r2);
	case (op)
		OP_BEQ:  return r1 == r2;
		OP_BNE:  return r1 != r2;
		OP_BLEZ: return $signed(r1) <= 0;
		OP_BGTZ: return $signed(r1) > 0;
		OP_BLTZ: return $signed(r1) < 0;
		default: return $signed(r1) >= 0;
	endcase
endfunction

function automatic int access_size(oper_t op);
	case (op)
		OP_LB, OP_SB: return 1;
		OP_LH, OP_SH: return 2;
		default:      return 4;
	endcase
endfunction

task automatic test_alu(oper_t op);
	uint32_t r1, r2, word, exp;
	int      i;
	tests++;
	for (i = 0; i < 4; i++) begin
		r1 = next_rand();
		r2 = next_rand();
		word = next_rand();
		if (op == OP_CLZ || op == OP_CLO) begin
			r1 = (i == 3) ? 32'h0 : r1 >> word[4:0];
			if (op == OP_CLO)
				r1 = ~r1;
		end
		exp = alu_model(op, r1, r2, word);
		@(posedge clk);
		delayslot <= (i == 1);
		data <= make_op(op, r1, r2, word);
		@(negedge clk);
		if (result.result !== exp)
			report_mismatch($sformatf("result.result (%s)", op.name()), result.result, exp);
		if (result.ex.valid !== 1'b0)
			report_failure($sformatf("%s raised an unexpected exception", op.name()));
		if (result.valid !== 1'b1)
			report_failure($sformatf("%s gave no valid result", op.name()));
		if (result.pc !== TEST_PC)
			report_mismatch("result.pc", result.pc, TEST_PC);
		if (result.delayslot !== (i == 1))
			report_mismatch("result.delayslot", result.delayslot, (i == 1));
	end
endtask

task automatic test_exception(oper_t op, uint32_t r1, uint32_t r2, uint32_t word,
	logic [4:0] code);
	uint64_t hilo_before;
	virt_t   addr;
	tests++;
	addr = r1 + {{16{word[15]}}, word[15:0]};
	hilo_before = hilo;
	apply(make_op(op, r1, r2, word));
	if (result.ex.valid !== 1'b1)
		report_failure($sformatf("%s did not raise an exception", op.name()));
	if (result.ex.exc_code !== code)
		report_mismatch("result.ex.exc_code", result.ex.exc_code, code);
	if ((code == `EXCCODE_ADEL || code == `EXCCODE_ADES) && result.ex.extra !== addr)
		report_mismatch("result.ex.extra", result.ex.extra, addr);
	@(negedge clk);
	if (hilo !== hilo_before)
		report_mismatch("hilo", hilo, hilo_before);
endtask

task automatic test_mem(oper_t op);
	uint32_t    base, r2, addr, mask, exp_wr;
	logic [3:0] exp_be;
	logic       is_store;
	int         size;
	int         off;
	int         k;
	tests++;
	size = access_size(op);
	is_store = op inside {OP_SB, OP_SH, OP_SW};
	for (off = 0; off < 4; off++) begin
		base = next_rand() & 32'hffff_fff0;
		r2 = next_rand();
		addr = base + 32'h20 + 32'(off);
		apply(make_op(op, base, r2, 32'h20 + 32'(off)));
		if (result.memreq.vaddr !== addr)
			report_mismatch("result.memreq.vaddr", result.memreq.vaddr, addr);
		if (result.memreq.paddr !== addr)
			report_mismatch("result.memreq.paddr", result.memreq.paddr, addr);
		if (result.memreq.read !== !is_store)
			report_mismatch("result.memreq.read", result.memreq.read, !is_store);
		if (result.memreq.write !== is_store)
			report_mismatch("result.memreq.write", result.memreq.write, is_store);
		if (off % size != 0) begin
			if (result.ex.valid !== 1'b1)
				report_failure($sformatf("misaligned %s gave no exception", op.name()));
			continue;
		end
		case (size)
			1: begin
				exp_be = 4'b0001 << off;
				exp_wr = {4{r2[7:0]}};
			end
			2: begin
				exp_be = (off == 2) ? 4'b1100 : 4'b0011;
				exp_wr = {2{r2[15:0]}};
			end
			default: begin
				exp_be = 4'b1111;
				exp_wr = r2;
			end
		endcase
		if (result.memreq.byteenable !== exp_be)
			report_mismatch("result.memreq.byteenable", result.memreq.byteenable, exp_be);
		// only the enabled lanes carry store data
		for (k = 0; k < 4; k++)
			mask[8*k +: 8] = {8{exp_be[k]}};
		if (is_store && (result.memreq.wrdata & mask) !== (exp_wr & mask))
			report_mismatch("result.memreq.wrdata", result.memreq.wrdata & mask,
				exp_wr & mask);
	end
endtask

task automatic test_mdu(oper_t op, uint32_t r1, uint32_t r2);
	uint64_t exp;
	int      cycles;
	tests++;
	exp = mdu_model(op, r1, r2);
	cycles = 0;
	apply(make_op(op, r1, r2, 32'h0));
	while (stall_req === 1'b1 && cycles < MDU_STEPS + 8) begin
		@(negedge clk);
		cycles++;
	end
	if (stall_req !== 1'b0) begin
		report_failure($sformatf("stall_req never fell during %s", op.name()));
	end else begin
		if (cycles != MDU_STEPS + 1)
			report_mismatch("stall_req cycles", cycles, MDU_STEPS + 1);
		if (result.hiloreq.we !== 1'b1)
			report_failure("result.hiloreq.we low when stall_req fell");
		if (result.hiloreq.wdata !== exp)
			report_mismatch("result.hiloreq.wdata", result.hiloreq.wdata, exp);
	end
	@(posedge clk);
	data <= '0;
	@(negedge clk);
	if (hilo !== exp)
		report_mismatch($sformatf("hilo after %s", op.name()), hilo, exp);
	apply(make_op(OP_MFHI, 32'h0, 32'h0, 32'h0));
	if (result.result !== exp[63:32])
		report_mismatch("result.result (MFHI)", result.result, exp[63:32]);
	apply(make_op(OP_MFLO, 32'h0, 32'h0, 32'h0));
	if (result.result !== exp[31:0])
		report_mismatch("result.result (MFLO)", result.result, exp[31:0]);
endtask

task automatic test_branch(oper_t op, uint32_t r1, uint32_t r2);
	pipeline_decode_t d;
	uint32_t          word;
	virt_t            exp_target;
	logic             exp_taken;
	control_flow_t    exp_cf;
	tests++;
	word = next_rand() & 32'h0000_ffff;
	exp_taken = branch_taken_model(op, r1, r2);
	exp_cf = exp_taken ? ControlFlow_Branch : ControlFlow_None;
	exp_target = TEST_PC + 32'd4 + {{14{word[15]}}, word[15:0], 2'b00};
	d = make_op(op, r1, r2, word);
	// predictor always guesses taken with the right target
	d.branch_predict.cf = ControlFlow_Branch;
	d.branch_predict.predict_vaddr = exp_target;
	apply(d);
	if (resolved_branch.valid !== 1'b1)
		report_failure($sformatf("%s gave no resolved branch", op.name()));
	if (resolved_branch.taken !== exp_taken)
		report_mismatch($sformatf("resolved_branch.taken (%s)", op.name()),
			resolved_branch.taken, exp_taken);
	if (resolved_branch.cf !== exp_cf)
		report_mismatch("resolved_branch.cf", resolved_branch.cf, exp_cf);
	if (exp_taken && resolved_branch.target !== exp_target)
		report_mismatch("resolved_branch.target", resolved_branch.target, exp_target);
	if (resolved_branch.mispredict !== !exp_taken)
		report_mismatch("resolved_branch.mispredict", resolved_branch.mispredict, !exp_taken);
endtask

task automatic test_jump(oper_t op);
	pipeline_decode_t d;
	uint32_t          r1, word;
	virt_t            exp_target, pc4;
	control_flow_t    exp_cf;
	logic             exp_mispredict;
	tests++;
	r1 = next_rand() & 32'hffff_fffc;
	word = next_rand();
	pc4 = TEST_PC + 32'd4;
	d = make_op(op, r1, 32'h0, word);
	if (op == OP_JAL) begin
		exp_cf = ControlFlow_JumpImm;
		exp_target = {pc4[31:28], word[25:0], 2'b00};
		// stale target in the prediction
		d.branch_predict.predict_vaddr = exp_target + 32'd4;
		exp_mispredict = 1'b1;
	end else begin
		exp_cf = ControlFlow_JumpReg;
		exp_target = r1;
		d.branch_predict.predict_vaddr = r1;
		exp_mispredict = 1'b0;
	end
	d.branch_predict.cf = exp_cf;
	apply(d);
	if (resolved_branch.valid !== 1'b1)
		report_failure($sformatf("%s gave no resolved branch", op.name()));
	if (resolved_branch.pc !== TEST_PC)
		report_mismatch("resolved_branch.pc", resolved_branch.pc, TEST_PC);
	if (resolved_branch.taken !== 1'b1)
		report_mismatch("resolved_branch.taken", resolved_branch.taken, 1'b1);
	if (resolved_branch.cf !== exp_cf)
		report_mismatch("resolved_branch.cf", resolved_branch.cf, exp_cf);
	if (resolved_branch.target !== exp_target)
		report_mismatch("resolved_branch.target", resolved_branch.target, exp_target);
	if (resolved_branch.mispredict !== exp_mispredict)
		report_mismatch("resolved_branch.mispredict", resolved_branch.mispredict,
			exp_mispredict);
	if (result.result !== TEST_PC + 32'd8)
		report_mismatch("result.result (link)", result.result, TEST_PC + 32'd8);
endtask

task automatic test_cmov(oper_t op, uint32_t r2);
	uint32_t   r1;
	logic      moves;
	reg_addr_t exp_rd;
	tests++;
	r1 = next_rand();
	moves = (op == OP_MOVZ) ? (r2 == 0) : (r2 != 0);
	exp_rd = moves ? RD_INDEX : 5'd0;
	apply(make_op(op, r1, r2, 32'h0));
	if (result.decoded.rd !== exp_rd)
		report_mismatch($sformatf("result.decoded.rd (%s)", op.name()),
			result.decoded.rd, exp_rd);
	if (moves && result.result !== r1)
		report_mismatch("result.result", result.result, r1);
endtask

task automatic test_flush();
	uint64_t hilo_before;
	tests++;
	hilo_before = hilo;
	apply(make_op(OP_DIV, next_rand(), 32'd7, 32'h0));
	repeat (5) @(negedge clk);
	@(posedge clk);
	flush <= 1'b1;
	@(posedge clk);
	flush <= 1'b0;
	data <= '0;
	@(negedge clk);
	if (stall_req !== 1'b0)
		report_failure("stall_req still high in the cycle after flush");
	@(negedge clk);
	if (hilo !== hilo_before)
		report_mismatch("hilo after flush", hilo, hilo_before);
endtask

initial begin
	#(NUM_TESTS * 40 * CLK_PERIOD);
	$display("Error: timeout after %0d cycles, %0d tests started", NUM_TESTS * 40, tests);
	$display("Regression failed");
	$finish;
end

initial begin
	errors = 0;
	tests = 0;
	lcg_state = 32'd31379;
	rst = 1'b1;
	flush = 1'b0;
	delayslot = 1'b0;
	data = '0;
	repeat (3) @(posedge clk);
	rst <= 1'b0;
	@(negedge clk);
	if (stall_req !== 1'b0)
		report_mismatch("stall_req after reset", stall_req, 1'b0);
	if (hilo !== 64'h0)
		report_mismatch("hilo after reset", hilo, 64'h0);

	foreach (alu_ops[i])
		test_alu(alu_ops[i]);

	test_mem(OP_LB);
	test_mem(OP_SB);
	test_mem(OP_LH);
	test_mem(OP_SH);
	test_mem(OP_LW);
	test_mem(OP_SW);

	test_mdu(OP_MULT, next_rand(), next_rand());
	test_mdu(OP_MULT, 32'hffff_fff9, 32'd13);
	test_mdu(OP_MULTU, next_rand(), next_rand());
	test_mdu(OP_DIV, next_rand() | 32'h8000_0000, (next_rand() >> 20) | 32'd1);
	test_mdu(OP_DIV, next_rand() & 32'h7fff_ffff, -((next_rand() >> 20) | 32'd1));
	test_mdu(OP_DIV, next_rand() | 32'h8000_0000, -((next_rand() >> 20) | 32'd1));
	test_mdu(OP_DIVU, next_rand(), (next_rand() >> 16) | 32'd1);
	test_mdu(OP_DIVU, next_rand(), 32'h0);
	test_mdu(OP_DIV, next_rand() & 32'h7fff_ffff, 32'h0);

	// hilo is nonzero here, so a stray write would show
	test_exception(OP_ADD, 32'h7fff_ffff, 32'd1, 32'h0, `EXCCODE_OV);
	test_exception(OP_SUB, 32'h8000_0000, 32'd1, 32'h0, `EXCCODE_OV);
	test_exception(OP_TEQ, 32'h1234_5678, 32'h1234_5678, 32'h0, `EXCCODE_TR);
	test_exception(OP_SYSCALL, 32'h0, 32'h0, 32'h0, `EXCCODE_SYS);
	test_exception(OP_BREAK, 32'h0, 32'h0, 32'h0, `EXCCODE_BP);
	test_exception(OP_INVALID, 32'h0, 32'h0, 32'h0, `EXCCODE_RI);
	test_exception(OP_LW, next_rand() | 32'd1, 32'h0, 32'h0000_fff8, `EXCCODE_ADEL);
	test_exception(OP_LH, next_rand() | 32'd1, 32'h0, 32'h0000_0010, `EXCCODE_ADEL);
	test_exception(OP_SH, next_rand() | 32'd1, 32'h0, 32'h0000_0010, `EXCCODE_ADES);

	test_branch(OP_BEQ, 32'h55aa_0f0f, 32'h55aa_0f0f);
	test_branch(OP_BEQ, 32'h55aa_0f0f, 32'h55aa_0f0e);
	test_branch(OP_BNE, 32'h0000_0001, 32'h0000_0002);
	test_branch(OP_BNE, 32'h0000_0003, 32'h0000_0003);
	test_branch(OP_BLEZ, 32'h0, 32'h0);
	test_branch(OP_BLEZ, 32'hffff_ff00, 32'h0);
	test_branch(OP_BLEZ, 32'd5, 32'h0);
	test_branch(OP_BGTZ, 32'd5, 32'h0);
	test_branch(OP_BGTZ, 32'h0, 32'h0);
	test_branch(OP_BLTZ, 32'h8000_0000, 32'h0);
	test_branch(OP_BLTZ, 32'd1, 32'h0);
	test_branch(OP_BGEZ, 32'h0, 32'h0);
	test_branch(OP_BGEZ, 32'hffff_ffff, 32'h0);
	test_branch(OP_BGEZ, 32'h7fff_ffff, 32'h0);
	test_jump(OP_JAL);
	test_jump(OP_JALR);

	test_cmov(OP_MOVZ, 32'h0);
	test_cmov(OP_MOVZ, 32'h0000_0100);
	test_cmov(OP_MOVN, 32'h0);
	test_cmov(OP_MOVN, 32'h8000_0000);
	test_flush();

	@(posedge clk);
	data <= '0;
	$display("tests run: %0d, errors: %0d", tests, errors);
	if (errors == 0)
		$display("Regression passed");
	else
		$display("Regression failed");
	$finish;
end

endmodule

`default_nettype wire

/* hdl/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core
	import cpu_pkg::*;
#(
	parameter int MDU_STEPS = 32
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             flush,
	input  logic             delayslot,
	input  pipeline_decode_t data,
	output pipeline_exec_t   result,
	output branch_resolved_t resolved_branch,
	output logic             stall_req,
	output uint64_t          hilo
);

logic hilo_we;

// commit only once the mdu has released the stage
assign hilo_we = result.valid && !result.ex.valid && result.hiloreq.we
	&& !stall_req && !flush;

always_ff @(posedge clk) begin
	if (rst)
		hilo <= '0;
	else if (hilo_we)
		hilo <= result.hiloreq.wdata;
end

instr_exec #(
	.MDU_STEPS ( MDU_STEPS )
) i_instr_exec (
	.clk             ( clk             ),
	.rst             ( rst             ),
	.flush           ( flush           ),
	.delayslot       ( delayslot       ),
	.hilo            ( hilo            ),
	.data            ( data            ),
	.result          ( result          ),
	.resolved_branch ( resolved_branch ),
	.stall_req       ( stall_req       )
);

endmodule

`default_nettype wire

/* hdl/instr_exec.sv */
`include "cpu_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module instr_exec
	import cpu_pkg::*;
#(
	parameter int MDU_STEPS = 32
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             flush,
	input  logic             delayslot,
	input  uint64_t          hilo,
	input  pipeline_decode_t data,
	output pipeline_exec_t   result,
	output branch_resolved_t resolved_branch,
	output logic             stall_req
);

oper_t         op;
uint32_t       reg1, reg2, exec_ret, add_u, sub_u, clz_cnt, clo_cnt;
logic          ov_add, ov_sub, signed_lt, unsigned_lt, mdu_start;
uint64_t       mdu_ret;
decoded_t      decoded_out;
hilo_req_t     hiloreq;
virt_t         mem_vaddr;
uint32_t       imm_ext, mem_wrdata;
logic [3:0]    mem_sel;
logic          trap, unaligned, taken;
exception_t    ex;
control_flow_t cf;
virt_t         pc_plus4, target, target_i, target_j;

assign op   = data.decoded.op;
assign reg1 = data.reg1;
assign reg2 = data.reg2;

assign add_u  = reg1 + reg2;
assign sub_u  = reg1 - reg2;
assign ov_add = (reg1[31] == reg2[31]) && (reg1[31] != add_u[31]);
assign ov_sub = (reg1[31] != reg2[31]) && (reg1[31] != sub_u[31]);
assign signed_lt   = (reg1[31] != reg2[31]) ? reg1[31] : sub_u[31];
assign unsigned_lt = (reg1 < reg2);

count_bit i_clz (
	.bit_val ( 1'b0    ),
	.val     ( reg1    ),
	.count   ( clz_cnt )
);

count_bit i_clo (
	.bit_val ( 1'b1    ),
	.val     ( reg1    ),
	.count   ( clo_cnt )
);

assign mdu_start = data.valid
	&& (op == OP_MULT || op == OP_MULTU || op == OP_DIV || op == OP_DIVU);

multi_cycle_exec #(
	.MDU_STEPS ( MDU_STEPS )
) i_mdu (
	.clk     ( clk       ),
	.rst     ( rst       ),
	.flush   ( flush     ),
	.op      ( op        ),
	.reg1    ( reg1      ),
	.reg2    ( reg2      ),
	.start   ( mdu_start ),
	.ret     ( mdu_ret   ),
	.is_busy ( stall_req )
);

// failed conditional move writes nothing
always_comb begin
	decoded_out = data.decoded;
	if ((op == OP_MOVZ && reg2 != '0) || (op == OP_MOVN && reg2 == '0))
		decoded_out.rd = '0;
end

always_comb begin
	hiloreq.we = 1'b1;
	case (op)
		OP_MTHI: hiloreq.wdata = {reg1, hilo[31:0]};
		OP_MTLO: hiloreq.wdata = {hilo[63:32], reg1};
		OP_MULT, OP_MULTU, OP_DIV, OP_DIVU: hiloreq.wdata = mdu_ret;
		default: begin
			hiloreq.we    = 1'b0;
			hiloreq.wdata = '0;
		end
	endcase
end

always_comb begin
	case (op)
		OP_LUI:  exec_ret = {data.instr.i_fmt.imm, 16'b0};
		OP_AND:  exec_ret = reg1 & reg2;
		OP_OR:   exec_ret = reg1 | reg2;
		OP_XOR:  exec_ret = reg1 ^ reg2;
		OP_NOR:  exec_ret = ~(reg1 | reg2);
		OP_ADD, OP_ADDU: exec_ret = add_u;
		OP_SUB, OP_SUBU: exec_ret = sub_u;
		OP_SLT:  exec_ret = {31'b0, signed_lt};
		OP_SLTU: exec_ret = {31'b0, unsigned_lt};
		OP_CLZ:  exec_ret = clz_cnt;
		OP_CLO:  exec_ret = clo_cnt;
		OP_MOVZ, OP_MOVN: exec_ret = reg1;
		OP_MFHI: exec_ret = hilo[63:32];
		OP_MFLO: exec_ret = hilo[31:0];
		OP_SLL:  exec_ret = reg2 << data.instr.r_fmt.sa;
		OP_SRL:  exec_ret = reg2 >> data.instr.r_fmt.sa;
		OP_SRA:  exec_ret = $signed(reg2) >>> data.instr.r_fmt.sa;
		OP_SLLV: exec_ret = reg2 << reg1[4:0];
		OP_SRLV: exec_ret = reg2 >> reg1[4:0];
		OP_SRAV: exec_ret = $signed(reg2) >>> reg1[4:0];
		// link address skips the delay slot
		OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL: exec_ret = data.pc + 32'd8;
		default: exec_ret = '0;
	endcase
end

assign imm_ext   = {{16{data.instr.i_fmt.imm[15]}}, data.instr.i_fmt.imm};
assign mem_vaddr = reg1 + imm_ext;

always_comb begin
	case (op)
		OP_LW, OP_SW: begin
			mem_wrdata = reg2;
			mem_sel    = 4'b1111;
		end
		OP_LB, OP_LBU, OP_SB: begin
			mem_wrdata = reg2 << {mem_vaddr[1:0], 3'b000};
			mem_sel    = 4'b0001 << mem_vaddr[1:0];
		end
		OP_LH, OP_LHU, OP_SH: begin
			mem_wrdata = mem_vaddr[1] ? (reg2 << 16) : reg2;
			mem_sel    = mem_vaddr[1] ? 4'b1100 : 4'b0011;
		end
		default: begin
			mem_wrdata = '0;
			mem_sel    = '0;
		end
	endcase
end

always_comb begin
	case (op)
		OP_TEQ:  trap = (reg1 == reg2);
		OP_TNE:  trap = (reg1 != reg2);
		OP_TGE:  trap = !signed_lt;
		OP_TLT:  trap = signed_lt;
		OP_TGEU: trap = !unsigned_lt;
		OP_TLTU: trap = unsigned_lt;
		default: trap = 1'b0;
	endcase
	case (op)
		OP_LW, OP_SW: unaligned = |mem_vaddr[1:0];
		OP_LH, OP_LHU, OP_SH: unaligned = mem_vaddr[0];
		default: unaligned = 1'b0;
	endcase
end

// priority RI > TR > BP > SYS > OV > address error
always_comb begin
	ex = '0;
	ex.valid = 1'b1;
	if (op == OP_INVALID) begin
		ex.exc_code = `EXCCODE_RI;
	end else if (trap) begin
		ex.exc_code = `EXCCODE_TR;
	end else if (op == OP_BREAK) begin
		ex.exc_code = `EXCCODE_BP;
	end else if (op == OP_SYSCALL) begin
		ex.exc_code = `EXCCODE_SYS;
	end else if ((op == OP_ADD && ov_add) || (op == OP_SUB && ov_sub)) begin
		ex.exc_code = `EXCCODE_OV;
	end else if (unaligned) begin
		ex.exc_code = data.decoded.is_store ? `EXCCODE_ADES : `EXCCODE_ADEL;
		ex.extra    = mem_vaddr;
	end else begin
		ex.valid = 1'b0;
	end
	if (!data.valid)
		ex = '0;
end

always_comb begin
	result.valid     = data.valid;
	result.pc        = data.pc;
	result.delayslot = delayslot;
	result.decoded   = decoded_out;
	result.result    = exec_ret;
	result.ex        = ex;
	result.hiloreq   = hiloreq;
	result.memreq.read       = data.decoded.is_load;
	result.memreq.write      = data.decoded.is_store;
	result.memreq.vaddr      = mem_vaddr;
	result.memreq.paddr      = mem_vaddr;
	result.memreq.wrdata     = mem_wrdata;
	result.memreq.byteenable = mem_sel;
end

assign pc_plus4 = data.pc + 32'd4;
assign target_i = pc_plus4 + {{14{data.instr.i_fmt.imm[15]}}, data.instr.i_fmt.imm, 2'b00};
assign target_j = {pc_plus4[31:28], data.instr.j_fmt.target, 2'b00};

always_comb begin
	case (op)
		OP_BEQ:  taken = (reg1 == reg2);
		OP_BNE:  taken = (reg1 != reg2);
		OP_BLEZ: taken = (reg1 == '0) || reg1[31];
		OP_BGTZ: taken = (reg1 != '0) && !reg1[31];
		OP_BLTZ, OP_BLTZAL: taken = reg1[31];
		OP_BGEZ, OP_BGEZAL: taken = !reg1[31];
		default: taken = 1'b1;
	endcase
	cf     = ControlFlow_None;
	target = '0;
	case (op)
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL: begin
			if (taken)
				cf = ControlFlow_Branch;
			target = target_i;
		end
		OP_J, OP_JAL: begin
			cf     = ControlFlow_JumpImm;
			target = target_j;
		end
		OP_JR, OP_JALR: begin
			cf     = ControlFlow_JumpReg;
			target = reg1;
		end
		default: ;
	endcase
end

// target only matters when control actually leaves the fall-through path
always_comb begin
	resolved_branch.valid  = data.valid && data.decoded.is_controlflow;
	resolved_branch.pc     = data.pc;
	resolved_branch.taken  = taken;
	resolved_branch.cf     = cf;
	resolved_branch.target = target;
	resolved_branch.mispredict = (cf != data.branch_predict.cf)
		|| (cf != ControlFlow_None && target != data.branch_predict.predict_vaddr);
end

// upstream holds the operation while the mdu iterates
a_data_held: assert property (@(posedge clk) disable iff (rst)
	stall_req && !flush |=> $stable(data));

endmodule

`default_nettype wire

/* hdl/multi_cycle_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module multi_cycle_exec
	import cpu_pkg::*;
#(
	parameter int MDU_STEPS = 32
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    flush,
	input  oper_t   op,
	input  uint32_t reg1,
	input  uint32_t reg2,
	input  logic    start,
	output uint64_t ret,
	output logic    is_busy
);

mdu_op_t kind;
logic    signed_op, neg_a, neg_b;
logic    load, step, last;
logic    is_div_q, neg_rem_q, neg_res_q;
uint32_t abs_a, abs_b;
uint64_t raw;

always_comb begin
	case (op)
		OP_MULT: kind = MDU_MULT;
		OP_DIVU: kind = MDU_DIVU;
		OP_DIV:  kind = MDU_DIV;
		default: kind = MDU_MULTU;
	endcase
end

assign signed_op = (kind == MDU_MULT) || (kind == MDU_DIV);
assign neg_a = signed_op && reg1[31];
assign neg_b = signed_op && reg2[31];
assign abs_a = neg_a ? -reg1 : reg1;
assign abs_b = neg_b ? -reg2 : reg2;

// remainder follows dividend sign
always_ff @(posedge clk) begin
	if (rst) begin
		is_div_q  <= 1'b0;
		neg_rem_q <= 1'b0;
		neg_res_q <= 1'b0;
	end else if (load) begin
		is_div_q  <= (kind == MDU_DIVU) || (kind == MDU_DIV);
		neg_rem_q <= neg_a;
		neg_res_q <= neg_a ^ neg_b;
	end
end

always_comb begin
	if (is_div_q) begin
		ret[63:32] = neg_rem_q ? -raw[63:32] : raw[63:32];
		ret[31:0]  = neg_res_q ? -raw[31:0] : raw[31:0];
	end else begin
		ret = neg_res_q ? -raw : raw;
	end
end

mdu_fsm i_fsm (
	.clk   ( clk     ),
	.rst   ( rst     ),
	.flush ( flush   ),
	.start ( start   ),
	.last  ( last    ),
	.load  ( load    ),
	.step  ( step    ),
	.busy  ( is_busy )
);

mdu_counter #(
	.MDU_STEPS ( MDU_STEPS )
) i_counter (
	.clk  ( clk  ),
	.rst  ( rst  ),
	.load ( load ),
	.step ( step ),
	.last ( last )
);

mdu_datapath i_datapath (
	.clk  ( clk   ),
	.rst  ( rst   ),
	.load ( load  ),
	.step ( step  ),
	.kind ( kind  ),
	.a    ( abs_a ),
	.b    ( abs_b ),
	.ret  ( raw   )
);

endmodule

`default_nettype wire

/* hdl/mdu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_datapath
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    load,
	input  logic    step,
	input  mdu_op_t kind,
	input  uint32_t a,
	input  uint32_t b,
	output uint64_t ret
);

// acc is the product high half or the partial remainder
uint32_t     acc, shreg, opnd;
logic        is_div;
logic [32:0] mul_sum, div_shift, div_diff;

assign is_div    = (kind == MDU_DIVU) || (kind == MDU_DIV);
assign mul_sum   = {1'b0, acc} + (shreg[0] ? {1'b0, opnd} : 33'd0);
assign div_shift = {acc, shreg[31]};
assign div_diff  = div_shift - {1'b0, opnd};

always_ff @(posedge clk) begin
	if (rst) begin
		acc   <= '0;
		shreg <= '0;
		opnd  <= '0;
	end else if (load) begin
		acc   <= '0;
		shreg <= a;
		opnd  <= b;
	end else if (step) begin
		if (!is_div) begin
			acc   <= mul_sum[32:1];
			shreg <= {mul_sum[0], shreg[31:1]};
		end else if (div_diff[32]) begin
			// restore
			acc   <= div_shift[31:0];
			shreg <= {shreg[30:0], 1'b0};
		end else begin
			acc   <= div_diff[31:0];
			shreg <= {shreg[30:0], 1'b1};
		end
	end
end

// {hi, lo} for mult, {remainder, quotient} for div
assign ret = {acc, shreg};

endmodule

`default_nettype wire

/* hdl/mdu_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_counter #(
	parameter int MDU_STEPS = 32
) (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic step,
	output logic last
);

localparam int CNT_W = $clog2(MDU_STEPS);

logic [CNT_W-1:0] cnt;

assign last = step && (cnt == '0);

always_ff @(posedge clk) begin
	if (rst)
		cnt <= '0;
	else if (load)
		cnt <= CNT_W'(MDU_STEPS - 1);
	else if (step)
		cnt <= cnt - 1'b1;
end

// fsm must leave run right after the final step
a_no_step_after_last: assert property (@(posedge clk) disable iff (rst)
	last |=> !step);

endmodule

`default_nettype wire

/* hdl/mdu_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module mdu_fsm (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic start,
	input  logic last,
	output logic load,
	output logic step,
	output logic busy
);

typedef enum logic [1:0] { S_IDLE, S_RUN, S_DONE } state_t;

state_t state, state_nxt;

assign load = (state == S_IDLE) && start && !flush;
assign step = (state == S_RUN);
// done state already lets the result through
assign busy = load || step;

always_comb begin
	state_nxt = state;
	case (state)
		S_IDLE: begin
			if (load)
				state_nxt = S_RUN;
		end
		S_RUN: begin
			if (last)
				state_nxt = S_DONE;
		end
		default: state_nxt = S_IDLE;
	endcase
	if (flush)
		state_nxt = S_IDLE;
end

always_ff @(posedge clk) begin
	if (rst)
		state <= S_IDLE;
	else
		state <= state_nxt;
end

// a running operation keeps its start level until done or flushed
a_start_held: assert property (@(posedge clk) disable iff (rst)
	step |-> start || flush);

endmodule

`default_nettype wire

/* hdl/count_bit.sv */
`timescale 1ns/1ps
`default_nettype none

module count_bit
	import cpu_pkg::*;
(
	input  logic    bit_val,
	input  uint32_t val,
	output uint32_t count
);

// highest mismatching bit wins
always_comb begin
	count = 32'd32;
	for (int i = 0; i < 32; i++) begin
		if (val[i] != bit_val)
			count = 32'(31 - i);
	end
end

endmodule

`default_nettype wire

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [63:0] uint64_t;
typedef logic [31:0] virt_t;
typedef logic [4:0]  reg_addr_t;

typedef enum logic [5:0] {
	OP_INVALID,
	OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
	OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI,
	OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
	OP_CLZ, OP_CLO, OP_MOVZ, OP_MOVN,
	OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
	OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
	OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW,
	OP_TEQ, OP_TNE, OP_TGE, OP_TLT, OP_TGEU, OP_TLTU,
	OP_SYSCALL, OP_BREAK,
	OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
	OP_J, OP_JAL, OP_JR, OP_JALR
} oper_t;

// raw instruction word, three encodings
typedef struct packed {
	logic [5:0] op;
	reg_addr_t  rs;
	reg_addr_t  rt;
	reg_addr_t  rd;
	logic [4:0] sa;
	logic [5:0] funct;
} r_fmt_t;

typedef struct packed {
	logic [5:0]  op;
	reg_addr_t   rs;
	reg_addr_t   rt;
	logic [15:0] imm;
} i_fmt_t;

typedef struct packed {
	logic [5:0]  op;
	logic [25:0] target;
} j_fmt_t;

typedef union packed {
	r_fmt_t r_fmt;
	i_fmt_t i_fmt;
	j_fmt_t j_fmt;
} instr_t;

typedef struct packed {
	oper_t     op;
	reg_addr_t rd;
	logic      is_load;
	logic      is_store;
	logic      is_controlflow;
} decoded_t;

typedef enum logic [1:0] {
	ControlFlow_None,
	ControlFlow_Branch,
	ControlFlow_JumpImm,
	ControlFlow_JumpReg
} control_flow_t;

typedef struct packed {
	control_flow_t cf;
	virt_t         predict_vaddr;
} branch_predict_t;

typedef struct packed {
	logic            valid;
	virt_t           pc;
	instr_t          instr;
	branch_predict_t branch_predict;
	decoded_t        decoded;
	uint32_t         reg1;
	uint32_t         reg2;
} pipeline_decode_t;

typedef struct packed {
	logic       valid;
	logic [4:0] exc_code;
	virt_t      extra;
} exception_t;

typedef struct packed {
	logic    we;
	uint64_t wdata;
} hilo_req_t;

// no MMU, paddr mirrors vaddr
typedef struct packed {
	logic       read;
	logic       write;
	virt_t      vaddr;
	uint32_t    paddr;
	uint32_t    wrdata;
	logic [3:0] byteenable;
} mem_req_t;

typedef struct packed {
	logic       valid;
	virt_t      pc;
	logic       delayslot;
	decoded_t   decoded;
	uint32_t    result;
	exception_t ex;
	hilo_req_t  hiloreq;
	mem_req_t   memreq;
} pipeline_exec_t;

typedef struct packed {
	logic          valid;
	virt_t         pc;
	logic          taken;
	control_flow_t cf;
	virt_t         target;
	logic          mispredict;
} branch_resolved_t;

typedef enum logic [1:0] {
	MDU_MULTU,
	MDU_MULT,
	MDU_DIVU,
	MDU_DIV
} mdu_op_t;

endpackage

`default_nettype wire

/* include/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// cause register codes
`define EXCCODE_ADEL 5'h04
`define EXCCODE_ADES 5'h05
`define EXCCODE_SYS  5'h08
`define EXCCODE_BP   5'h09
`define EXCCODE_RI   5'h0a
`define EXCCODE_OV   5'h0c
`define EXCCODE_TR   5'h0d

`endif
